// File: logic/tcb_lite_pkg.sv
////////////////////
// TCB-lite bus protocol definitions
// sizes, bus modes and the data word views
////////////////////

`default_nettype none

package tcb_lite_pkg;

    ////////////////////
    // widths
    ////////////////////

    localparam int unsigned DAT_W = 32;  // data width
    localparam int unsigned BYT_W = 4;   // byte lanes per word
    localparam int unsigned SIZ_W = 2;   // logarithmic size field

    // bus mode, lanes from size/offset or straight from byte enables
    typedef enum logic {
        MODE_LOG = 1'b0,  // logarithmic size
        MODE_BYT = 1'b1   // byte enable
    } tcb_mode_e;

    // transfer size, log2 of the byte count
    typedef enum logic [SIZ_W-1:0] {
        SIZ_BYTE = 2'd0,
        SIZ_HALF = 2'd1,
        SIZ_WORD = 2'd2   // 2'd3 reserved
    } tcb_siz_e;

    // one data word, as a whole or per byte lane
    typedef union packed {
        logic [DAT_W-1:0]      wrd;  // lane shifting
        logic [BYT_W-1:0][7:0] byt;  // byte order swap
    } tcb_dat_u;

endpackage

`default_nettype wire

// File: logic/tcb_mem_pkg.sv
////////////////////
// on-chip memory definitions
////////////////////

`default_nettype none

package tcb_mem_pkg;

    localparam int unsigned MEM_AW_DEF = 8;  // default word address width
    localparam int unsigned OFF_W      = 2;  // byte offset in a word

    // first byte address bit above the memory
    // word index sits right below it, on top of the offset
    function automatic int unsigned adr_top(input int unsigned aw);
        return aw + OFF_W;
    endfunction

endpackage

`default_nettype wire

// File: logic/tcb_lite_dec.sv
////////////////////
// TCB-lite request decoder
// lane enables, lane aligned write data, error flag
////////////////////

`default_nettype none

module tcb_lite_dec #(
    parameter tcb_lite_pkg::tcb_mode_e MOD    = tcb_lite_pkg::MODE_LOG,  // bus mode
    parameter int unsigned             MEM_AW = tcb_mem_pkg::MEM_AW_DEF  // word index width
)(
    input  logic                               clk,
    input  logic                               rst_n,
    // request from manager
    input  logic                               vld,    // request valid
    input  logic                               wen,    // 1 write, 0 read
    input  logic                               ndn,    // 1 big endian
    input  logic [tcb_lite_pkg::DAT_W-1:0]     adr,    // byte address
    input  tcb_lite_pkg::tcb_siz_e             siz,    // log size
    input  logic [tcb_lite_pkg::BYT_W-1:0]     byt,    // byte enables
    input  tcb_lite_pkg::tcb_dat_u             wdt,    // write data
    // decoded request
    output logic                               d_vld,
    output logic                               d_wen,
    output logic                               d_err,
    output logic                               d_ndn,
    output logic [MEM_AW-1:0]                  d_idx,  // word index
    output logic [tcb_lite_pkg::BYT_W-1:0]     d_ben,  // lane enables
    output tcb_lite_pkg::tcb_dat_u             d_wdt,  // lane aligned data
    output logic [tcb_mem_pkg::OFF_W-1:0]      d_off,
    output tcb_lite_pkg::tcb_siz_e             d_siz
);

    import tcb_lite_pkg::*;
    import tcb_mem_pkg::*;

    localparam int unsigned TOP = adr_top(MEM_AW);  // first bit past the memory

    logic [OFF_W-1:0] off;      // byte offset
    tcb_dat_u         wdt_swp;  // endian corrected
    tcb_dat_u         wdt_lan;  // shifted onto lanes
    logic [BYT_W-1:0] ben_siz;  // size mask at lane 0
    logic [BYT_W-1:0] ben;
    logic             mis;      // misaligned for size
    logic             oor;      // out of range
    logic             err;

    assign off = adr[OFF_W-1:0];
    assign oor = |adr[DAT_W-1:TOP];

    ////////////////////
    // logarithmic size path
    ////////////////////

    // big endian, reverse the low bytes of the transfer
    always_comb begin
        wdt_swp = wdt;
        if (ndn && (siz == SIZ_HALF)) begin
            wdt_swp.byt[0] = wdt.byt[1];
            wdt_swp.byt[1] = wdt.byt[0];
        end else if (ndn && (siz == SIZ_WORD)) begin
            for (int i = 0; i < BYT_W; i++) begin
                wdt_swp.byt[i] = wdt.byt[BYT_W-1-i];
            end
        end
    end

    assign wdt_lan.wrd = wdt_swp.wrd << {off, 3'b000};  // up by offset

    always_comb begin
        case (siz)
            SIZ_BYTE: begin
                ben_siz = 4'b0001;
                mis     = 1'b0;
            end
            SIZ_HALF: begin
                ben_siz = 4'b0011;
                mis     = off[0];
            end
            SIZ_WORD: begin
                ben_siz = 4'b1111;
                mis     = |off;
            end
            default: begin  // reserved size, always an error
                ben_siz = 4'b0000;
                mis     = 1'b1;
            end
        endcase
    end

    ////////////////////
    // mode select
    ////////////////////

    always_comb begin
        if (MOD == MODE_LOG) begin
            ben = ben_siz << off;
            err = oor | mis;
        end else begin
            ben = byt;          // lanes given directly
            err = oor | ~|byt;  // empty enable is an error
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            d_vld <= 1'b0;
        end else begin
            d_vld <= vld;
        end
    end

    // payload, captured only on a request
    always_ff @(posedge clk) begin
        if (vld) begin
            d_wen <= wen;
            d_err <= err;
            d_idx <= adr[TOP-1:OFF_W];
            d_ben <= ben;
            d_wdt <= (MOD == MODE_LOG) ? wdt_lan : wdt;
            d_off <= off;
            d_siz <= siz;
            d_ndn <= (MOD == MODE_LOG) ? ndn : 1'b0;  // ignored in byte enable mode
        end
    end

endmodule

`default_nettype wire

// File: logic/tcb_lite_mem.sv
////////////////////
// execute stage
// byte enabled memory, registered read
////////////////////

`default_nettype none

module tcb_lite_mem #(
    parameter int unsigned MEM_AW = tcb_mem_pkg::MEM_AW_DEF  // word index width
)(
    input  logic                               clk,
    input  logic                               rst_n,
    // decoded request
    input  logic                               d_vld,
    input  logic                               d_wen,
    input  logic                               d_err,
    input  logic                               d_ndn,
    input  logic [MEM_AW-1:0]                  d_idx,
    input  logic [tcb_lite_pkg::BYT_W-1:0]     d_ben,
    input  tcb_lite_pkg::tcb_dat_u             d_wdt,
    input  logic [tcb_mem_pkg::OFF_W-1:0]      d_off,
    input  tcb_lite_pkg::tcb_siz_e             d_siz,
    // to result stage
    output logic                               m_vld,
    output logic                               m_err,
    output logic                               m_ndn,
    output tcb_lite_pkg::tcb_dat_u             m_rdt,  // lane ordered word
    output logic [tcb_mem_pkg::OFF_W-1:0]      m_off,
    output tcb_lite_pkg::tcb_siz_e             m_siz
);

    import tcb_lite_pkg::*;

    logic [BYT_W-1:0][7:0] mem [2**MEM_AW];  // contents not reset

    // write enabled lanes, erroneous requests write nothing
    always_ff @(posedge clk) begin
        if (d_vld && d_wen && !d_err) begin
            for (int i = 0; i < BYT_W; i++) begin
                if (d_ben[i]) begin
                    mem[d_idx][i] <= d_wdt.byt[i];
                end
            end
        end
    end

    // read returns old data on a same edge write
    always_ff @(posedge clk) begin
        if (d_vld) begin
            m_rdt.wrd <= d_err ? '0 : mem[d_idx];
            m_err     <= d_err;
            m_off     <= d_off;  // realignment fields
            m_siz     <= d_siz;
            m_ndn     <= d_ndn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            m_vld <= 1'b0;
        end else begin
            m_vld <= d_vld;
        end
    end

endmodule

`default_nettype wire

// File: logic/tcb_lite_rsp.sv
////////////////////
// result stage
// response delay line and read data realignment
////////////////////

`default_nettype none

module tcb_lite_rsp #(
    parameter int unsigned             DLY = 3,                       // response delay, 2..8
    parameter tcb_lite_pkg::tcb_mode_e MOD = tcb_lite_pkg::MODE_LOG   // bus mode
)(
    input  logic                               clk,
    input  logic                               rst_n,
    // from execute stage
    input  logic                               m_vld,
    input  logic                               m_err,
    input  logic                               m_ndn,
    input  tcb_lite_pkg::tcb_dat_u             m_rdt,
    input  logic [tcb_mem_pkg::OFF_W-1:0]      m_off,
    input  tcb_lite_pkg::tcb_siz_e             m_siz,
    // response to manager
    output logic                               rsp_vld,
    output logic                               rsp_err,
    output logic [tcb_lite_pkg::DAT_W-1:0]     rsp_rdt
);

    import tcb_lite_pkg::*;
    import tcb_mem_pkg::*;

    localparam int unsigned PLD_W = 1 + DAT_W + OFF_W + SIZ_W + 1;  // err rdt off siz ndn

    logic             o_vld;  // delay line output
    logic             o_err;
    logic             o_ndn;
    tcb_dat_u         o_rdt;
    logic [OFF_W-1:0] o_off;
    logic [SIZ_W-1:0] o_siz;
    tcb_dat_u         sft;    // shifted down to lane 0
    tcb_dat_u         swp;    // masked and byte swapped

    ////////////////////
    // delay line, DLY-2 stages
    ////////////////////

    if (DLY == 2) begin : g_nodly
        assign o_vld = m_vld;
        assign {o_err, o_rdt, o_off, o_siz, o_ndn} = {m_err, m_rdt, m_off, m_siz, m_ndn};
    end else begin : g_dly
        logic             q_vld [DLY-2];
        logic [PLD_W-1:0] q_pld [DLY-2];

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                for (int i = 0; i < DLY-2; i++) begin
                    q_vld[i] <= 1'b0;
                end
            end else begin
                q_vld[0] <= m_vld;
                for (int i = 1; i < DLY-2; i++) begin
                    q_vld[i] <= q_vld[i-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            q_pld[0] <= {m_err, m_rdt, m_off, m_siz, m_ndn};
            for (int i = 1; i < DLY-2; i++) begin
                q_pld[i] <= q_pld[i-1];
            end
        end

        assign o_vld = q_vld[DLY-3];
        assign {o_err, o_rdt, o_off, o_siz, o_ndn} = q_pld[DLY-3];
    end

    ////////////////////
    // realignment
    ////////////////////

    assign sft.wrd = o_rdt.wrd >> {o_off, 3'b000};

    always_comb begin
        swp = sft;
        case (o_siz)
            SIZ_BYTE: swp.wrd = sft.wrd & 32'h0000_00ff;
            SIZ_HALF: begin
                swp.wrd = sft.wrd & 32'h0000_ffff;
                if (o_ndn) begin  // big endian half
                    swp.byt[0] = sft.byt[1];
                    swp.byt[1] = sft.byt[0];
                end
            end
            default: begin
                if (o_ndn) begin  // big endian word
                    for (int i = 0; i < BYT_W; i++) begin
                        swp.byt[i] = sft.byt[BYT_W-1-i];
                    end
                end
            end
        endcase
    end

    assign rsp_vld = o_vld;
    assign rsp_err = o_err;
    assign rsp_rdt = (MOD == MODE_LOG) ? swp.wrd : o_rdt.wrd;  // byte enable mode as is

endmodule

`default_nettype wire

// File: logic/tcb_lite_top.sv
////////////////////
// TCB-lite memory subordinate
// decode, execute and result stages
////////////////////

`default_nettype none

module tcb_lite_top #(
    parameter int unsigned             DLY    = 3,                        // response delay
    parameter tcb_lite_pkg::tcb_mode_e MOD    = tcb_lite_pkg::MODE_LOG,   // bus mode
    parameter int unsigned             MEM_AW = tcb_mem_pkg::MEM_AW_DEF   // word index width
)(
    input  logic                               clk,
    input  logic                               rst_n,
    // request
    input  logic                               vld,
    input  logic                               wen,
    input  logic                               ndn,
    input  logic [tcb_lite_pkg::DAT_W-1:0]     adr,
    input  tcb_lite_pkg::tcb_siz_e             siz,
    input  logic [tcb_lite_pkg::BYT_W-1:0]     byt,
    input  logic [tcb_lite_pkg::DAT_W-1:0]     wdt,
    // response, DLY cycles after the request
    output logic                               rsp_vld,
    output logic [tcb_lite_pkg::DAT_W-1:0]     rsp_rdt,
    output logic                               rsp_err
);

    import tcb_lite_pkg::*;
    import tcb_mem_pkg::*;

    ////////////////////
    // stage wires
    ////////////////////

    // decode to execute
    logic             d_vld;
    logic             d_wen;
    logic             d_err;
    logic             d_ndn;
    logic [MEM_AW-1:0] d_idx;
    logic [BYT_W-1:0] d_ben;
    tcb_dat_u         d_wdt;
    logic [OFF_W-1:0] d_off;
    tcb_siz_e         d_siz;

    // execute to result
    logic             m_vld;
    logic             m_err;
    logic             m_ndn;
    tcb_dat_u         m_rdt;
    logic [OFF_W-1:0] m_off;
    tcb_siz_e         m_siz;

    tcb_lite_dec #(.MOD(MOD), .MEM_AW(MEM_AW)) u_dec (
        .clk, .rst_n,
        .vld, .wen, .ndn, .adr, .siz, .byt, .wdt,
        .d_vld, .d_wen, .d_err, .d_ndn, .d_idx, .d_ben, .d_wdt, .d_off, .d_siz
    );

    tcb_lite_mem #(.MEM_AW(MEM_AW)) u_mem (
        .clk, .rst_n,
        .d_vld, .d_wen, .d_err, .d_ndn, .d_idx, .d_ben, .d_wdt, .d_off, .d_siz,
        .m_vld, .m_err, .m_ndn, .m_rdt, .m_off, .m_siz
    );

    tcb_lite_rsp #(.DLY(DLY), .MOD(MOD)) u_rsp (
        .clk, .rst_n,
        .m_vld, .m_err, .m_ndn, .m_rdt, .m_off, .m_siz,
        .rsp_vld, .rsp_err, .rsp_rdt
    );

endmodule

`default_nettype wire

// File: tests/tcb_lite_tb.sv
////////////////////
// TCB-lite memory subordinate testbench
// reference memory model, response queue, watchdog
////////////////////

`default_nettype none

module tcb_lite_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import tcb_lite_pkg::*;

    localparam int DLY   = 3;    // response delay of the DUT
    localparam int AW    = 6;    // word index width
    localparam int N_FIL = 64;   // one fill write per word
    localparam int N_DIR = 68;   // directed requests
    localparam int N_RND = 300;  // random requests
    localparam int N_REQ = N_FIL + N_DIR + N_RND;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        vld;
    logic        wen;
    logic        ndn;
    logic [31:0] adr;
    tcb_siz_e    siz;
    logic [3:0]  byt;
    logic [31:0] wdt;
    logic        rsp_vld;
    logic [31:0] rsp_rdt;
    logic        rsp_err;

    integer      seed = 32'hdd5;
    int          edge_cnt = 0;   // rising edges since time zero

    // reference memory
    logic [31:0] mdl_mem [2**AW];

    // expected responses in request order
    int          q_cyc [$];      // cycle the request is driven in
    logic [31:0] q_rdt [$];
    logic        q_err [$];

    tcb_lite_top #(.DLY(DLY), .MOD(MODE_LOG), .MEM_AW(AW)) dut0 (
        .clk, .rst_n,
        .vld, .wen, .ndn, .adr, .siz, .byt, .wdt,
        .rsp_vld, .rsp_rdt, .rsp_err
    );

    always #5 clk = ~clk;  // 10 ns period

    always @(posedge clk) edge_cnt <= edge_cnt + 1;

    ////////////////////
    // failure reporting
    ////////////////////

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    ////////////////////
    // reference model
    ////////////////////

    // byte k of a transfer sits in lane off+k
    // big endian puts it at position nb-1-k of the right aligned value
    function automatic void expect_rsp(input logic w, input logic n, input logic [31:0] a,
                                       input logic [1:0] s, input logic [31:0] d,
                                       output logic [31:0] rdt, output logic err);
        int          off;
        int          idx;
        int          nb;
        int          pos;
        logic [31:0] old;
        off = int'(a[1:0]);
        idx = int'(a[AW+1:2]);
        err = |a[31:AW+2];  // outside the memory
        case (s)
            2'd0:    nb = 1;
            2'd1:    nb = 2;
            2'd2:    nb = 4;
            default: nb = 0;  // reserved size
        endcase
        if (nb == 0) begin
            err = 1'b1;
        end else if ((off % nb) != 0) begin
            err = 1'b1;       // misaligned
        end
        old = mdl_mem[idx];
        rdt = 32'd0;
        if (!err) begin
            for (int k = 0; k < nb; k++) begin
                pos = n ? (nb - 1 - k) : k;
                rdt[8*pos +: 8] = old[8*(off+k) +: 8];  // old data, also on a write
            end
            if (w) begin
                for (int k = 0; k < nb; k++) begin
                    pos = n ? (nb - 1 - k) : k;
                    mdl_mem[idx][8*(off+k) +: 8] = d[8*pos +: 8];
                end
            end
        end
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h0101_0101) ^ {a[15:0], ~a[15:0]} ^ 32'h5a3c_c3a5;
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    // one request, accepted at the next rising edge
    task automatic send(input logic w, input logic n, input logic [31:0] a,
                        input logic [1:0] s, input logic [31:0] d);
        logic [31:0] e_rdt;
        logic        e_err;
        @(posedge clk);
        #1;
        vld = 1'b1;
        wen = w;
        ndn = n;
        adr = a;
        siz = tcb_siz_e'(s);
        byt = 4'h0;  // unused in log size mode
        wdt = d;
        expect_rsp(w, n, a, s, d, e_rdt, e_err);
        q_cyc.push_back(edge_cnt);
        q_rdt.push_back(e_rdt);
        q_err.push_back(e_err);
    endtask

    ////////////////////
    // compare process
    ////////////////////

    // sampled on the falling edge, outputs settled
    // empty queue check also covers rsp_vld during and after reset
    always @(negedge clk) begin : compare
        int          acc;
        logic [31:0] e_rdt;
        logic        e_err;
        if (edge_cnt > 0) begin
            if (rsp_vld === 1'b1) begin
                if (q_cyc.size() == 0) begin
                    fail_run($sformatf("response valid at cycle %0d with no request outstanding",
                                       edge_cnt));
                end
                acc   = q_cyc.pop_front();
                e_rdt = q_rdt.pop_front();
                e_err = q_err.pop_front();
                if (edge_cnt != acc + DLY) begin
                    fail_run($sformatf("response at cycle %0d for a request accepted at cycle %0d",
                                       edge_cnt, acc));
                end
                check({31'd0, rsp_err}, {31'd0, e_err}, "rsp_err");
                check(rsp_rdt, e_rdt, "rsp_rdt");
            end else if (rsp_vld !== 1'b0) begin
                fail_run("response valid is unknown");
            end else if (q_cyc.size() != 0 && q_cyc[0] + DLY <= edge_cnt) begin
                fail_run($sformatf("no response for the request accepted at cycle %0d",
                                   q_cyc[0]));
            end
        end
    end

    // whole run bounded by the request count
    initial begin : watchdog
        #((N_REQ + DLY + 20) * 10);
        fail_run("timeout, the run did not finish in time");
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin : main
        logic [31:0] a;
        logic [31:0] r;
        logic [1:0]  s;
        rst_n = 1'b0;
        vld   = 1'b0;
        wen   = 1'b0;
        ndn   = 1'b0;
        adr   = 32'd0;
        siz   = SIZ_WORD;
        byt   = 4'h0;
        wdt   = 32'd0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // fill every word, no unknown reads later
        for (int i = 0; i < N_FIL; i++) begin
            a = 32'(i * 4);
            send(1'b1, 1'b0, a, 2'd2, fill_word(a));
        end

        // word writes and reads, both byte orders
        for (int i = 0; i < 4; i++) begin
            send(1'b1, i[0], 32'((16 + i) * 4), 2'd2, $random(seed));
        end
        for (int i = 0; i < 4; i++) begin
            send(1'b0, 1'b0, 32'((16 + i) * 4), 2'd2, 32'd0);
            send(1'b0, 1'b1, 32'((16 + i) * 4), 2'd2, 32'd0);
        end

        // byte and half merges, per endianness
        for (int n = 0; n < 2; n++) begin
            a = 32'((32 + n) * 4);
            send(1'b1, 1'b0, a, 2'd2, 32'h1122_3344);
            for (int o = 0; o < 4; o++) begin
                send(1'b1, n[0], a + 32'(o), 2'd0, $random(seed));
            end
            for (int o = 0; o < 4; o++) begin
                send(1'b0, n[0], a + 32'(o), 2'd0, 32'd0);
            end
            for (int o = 0; o < 4; o += 2) begin
                send(1'b1, n[0], a + 32'(o), 2'd1, $random(seed));
            end
            for (int o = 0; o < 4; o += 2) begin
                send(1'b0, n[0], a + 32'(o), 2'd1, 32'd0);
            end
            send(1'b0, n[0], a, 2'd2, 32'd0);
        end

        // errors, nothing written
        a = 32'(40 * 4);
        send(1'b1, 1'b0, a, 2'd2, 32'hcafe_f00d);
        send(1'b1, 1'b0, a + 32'd1, 2'd1, $random(seed));  // misaligned half
        send(1'b1, 1'b1, a + 32'd3, 2'd1, $random(seed));
        send(1'b1, 1'b0, a + 32'd1, 2'd2, $random(seed));  // misaligned word
        send(1'b1, 1'b1, a + 32'd2, 2'd2, $random(seed));
        send(1'b1, 1'b0, a + 32'd3, 2'd2, $random(seed));
        send(1'b1, 1'b0, a, 2'd3, $random(seed));           // reserved size
        send(1'b1, 1'b0, a | 32'h0000_0100, 2'd2, $random(seed));  // out of range
        send(1'b1, 1'b0, a | 32'h8000_0000, 2'd2, $random(seed));
        send(1'b0, 1'b0, a + 32'd1, 2'd1, 32'd0);
        send(1'b0, 1'b0, a | 32'h0001_0000, 2'd2, 32'd0);
        send(1'b0, 1'b0, a, 2'd2, 32'd0);                   // still the first word

        // read right after a write to the same word
        for (int i = 0; i < 4; i++) begin
            a = 32'((48 + i) * 4);
            send(1'b1, 1'b0, a, 2'd2, $random(seed));
            send(1'b0, 1'b0, a, 2'd2, 32'd0);
            send(1'b1, 1'b1, a + 32'd2, 2'd0, $random(seed));
            send(1'b0, 1'b1, a + 32'd2, 2'd1, 32'd0);
        end

        // random mixed traffic
        for (int i = 0; i < N_RND; i++) begin
            r = $random(seed);
            a = {24'd0, r[7:0]};
            s = r[11:10];
            if (r[20]) begin  // mostly aligned
                if (s == 2'd1) begin
                    a[0] = 1'b0;
                end else if (s == 2'd2) begin
                    a[1:0] = 2'b00;
                end
            end
            if (r[15:12] == 4'h0) begin
                a[16 + int'(r[19:16])] = 1'b1;  // outside the memory
            end
            send(r[8], r[9], a, s, $random(seed));
        end

        @(posedge clk);
        #1;
        vld = 1'b0;

        while (q_cyc.size() != 0) begin
            @(posedge clk);
        end
        repeat (DLY + 2) @(posedge clk);  // no stray responses
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tcb_lite_top.f
logic/tcb_lite_pkg.sv
logic/tcb_mem_pkg.sv
logic/tcb_lite_dec.sv
logic/tcb_lite_mem.sv
logic/tcb_lite_rsp.sv
logic/tcb_lite_top.sv
tests/tcb_lite_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the TCB-lite testbench with Verilator
# exit status is nonzero when the testbench fails

set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module tcb_lite_tb \
    -f tcb_lite_top.f \
    -o tcb_lite_sim

./obj_dir/tcb_lite_sim

echo "simulation finished"
